/* wb_tests.txt */
# M mode | D drain | R addr expected
# I unit op rd a b expected rank gap, hex, rank = write-back position since last drain
I 1 5 01 00000007 00000006 0000002a 0 1
I 0 0 02 0000000a 00000005 0000000f 1 1
I 0 1 03 00000005 00000008 fffffffd 2 1
I 0 2 04 f0f0ff00 0ff00ff0 00f00f00 3 0
I 0 3 05 12340000 00005678 12345678 4 0
D
R 01 0000002a
R 03 fffffffd
I 1 5 07 00010000 00010001 00010000 0 1
M 0
I 0 0 08 00000001 00000002 00000003 1 0
I 0 4 09 000000ff 0000000f 000000f0 2 0
D
I 1 5 0a 00000003 00000005 0000000f 1 1
I 0 0 0b 00000001 00000001 00000002 0 0
I 1 5 0c fffffffe 00000003 fffffffa 3 0
I 0 1 0d 00000000 00000001 ffffffff 2 0
D
I 0 0 00 00000005 00000005 0000000a 0 1
D
R 00 00000000
R 0b 00000002
I 1 5 0e 00000004 00000004 00000010 1 1
I 0 3 0f 000000f0 0000000f 000000ff 0 0
M 1
D
I 1 5 10 00000009 00000009 00000051 0 1
I 0 2 11 0000ffff 00ff00ff 000000ff 1 0
I 0 1 02 00000064 00000001 00000063 2 0
D
R 02 00000063
R 10 00000051

/* list.f */
+incdir+.
wb_pkg.sv
id_order_stack.sv
write_back.sv
wb_mode_ctrl.sv
exec_units.sv
reg_file.sv
wb_top.sv
wb_properties.sv
wb_tb.sv

/* wb_tb.sv */
/*
 * Testbench for wb_top, records come from wb_tests.txt
 * Issue ranks assume back-to-back issue inside out-of-order groups
 * At most 64 records, at most 16 write-backs between drains
 */
`include "wb_settings.svh"

module wb_tb;
    import wb_pkg::*;

    localparam int PERIOD            = 40;
    localparam int DRIVE_DELAY       = 2;
    localparam int RESET_CYCLES      = 10;
    localparam int CYCLES_PER_RECORD = 64;
    localparam int MAX_RECS          = 64;

    logic                clk;
    logic                rst;
    logic                issue;
    unit_t               issue_unit;
    alu_op_t             issue_op;
    reg_addr_t           issue_rd;
    logic [`WB_XLEN-1:0] issue_a;
    logic [`WB_XLEN-1:0] issue_b;
    logic                cfg_write;
    logic                cfg_inorder;
    reg_addr_t           rd_addr;
    logic                id_available;
    instruction_id_t     issue_id;
    logic                queue_empty;
    instruction_id_t     oldest_id;
    logic                inorder;
    logic                wb_valid;
    instruction_id_t     wb_id;
    reg_addr_t           wb_rd;
    logic [`WB_XLEN-1:0] wb_data;
    logic [`WB_XLEN-1:0] rd_data;

    // Test records, kind letter plus up to eight hex fields
    logic [7:0]  rec_kind [MAX_RECS];
    logic [31:0] rec_f [MAX_RECS][8];
    int          rec_count;

    // Scoreboard keyed by ID
    logic                busy [`WB_INFLIGHT];
    reg_addr_t           exp_rd [`WB_INFLIGHT];
    logic [`WB_XLEN-1:0] exp_data [`WB_INFLIGHT];
    instruction_id_t     rank_id [16];
    instruction_id_t     issue_order [$];
    int                  outstanding;
    int                  group_pos;

    // Expected mode register
    logic mode_model;
    logic mode_pending;
    logic mode_req;

    logic monitor_on;
    int   cycle_count;
    int   cycle_limit;

    wb_top dut (
        .clk(clk), .rst(rst), .issue(issue), .issue_unit(issue_unit),
        .issue_op(issue_op), .issue_rd(issue_rd), .issue_a(issue_a), .issue_b(issue_b),
        .cfg_write(cfg_write), .cfg_inorder(cfg_inorder), .rd_addr(rd_addr),
        .id_available(id_available), .issue_id(issue_id), .queue_empty(queue_empty),
        .oldest_id(oldest_id), .inorder(inorder), .wb_valid(wb_valid), .wb_id(wb_id),
        .wb_rd(wb_rd), .wb_data(wb_data), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic compare_id(input string name, input instruction_id_t exp,
                              input instruction_id_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t exp,
                                  input reg_addr_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic verify_word(input string name, input logic [`WB_XLEN-1:0] exp,
                               input logic [`WB_XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic match_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] v [8];
        fd = $fopen("wb_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open wb_tests.txt");
            stop_with_failure();
        end
        rec_count = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                foreach (v[i])
                    v[i] = '0;
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", kind,
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (rec_count == MAX_RECS) begin
                    $display("Too many records in wb_tests.txt");
                    stop_with_failure();
                end
                rec_kind[rec_count] = kind;
                rec_f[rec_count] = v;
                rec_count++;
            end
        end
        $fclose(fd);
    endtask

    // Fields: unit op rd a b expected rank gap
    task automatic issue_instr(input int r);
        int              gap;
        instruction_id_t id;
        gap = 0;
        if (rec_f[r][7] != 0)
            gap = $urandom % 4;
        repeat (gap) tick();
        // Back-pressure from a full stack
        while (!id_available)
            tick();
        id = issue_id;
        issue      = 1'b1;
        issue_unit = unit_t'(rec_f[r][0][0]);
        issue_op   = alu_op_t'(rec_f[r][1][2:0]);
        issue_rd   = reg_addr_t'(rec_f[r][2][4:0]);
        issue_a    = rec_f[r][3];
        issue_b    = rec_f[r][4];
        tick();
        issue = 1'b0;
        if (busy[id]) begin
            $display("ID %0d handed out while still in flight", id);
            stop_with_failure();
        end
        busy[id]     = 1'b1;
        exp_rd[id]   = reg_addr_t'(rec_f[r][2][4:0]);
        exp_data[id] = rec_f[r][5];
        rank_id[rec_f[r][6][3:0]] = id;
        issue_order.push_back(id);
        outstanding++;
    endtask

    task automatic write_mode(input logic value);
        cfg_inorder = value;
        cfg_write   = 1'b1;
        tick();
        cfg_write = 1'b0;
    endtask

    task automatic drain_queue();
        while (outstanding != 0)
            tick();
        group_pos = 0;
    endtask

    task automatic read_register(input reg_addr_t addr, input logic [`WB_XLEN-1:0] exp);
        rd_addr = addr;
        @(negedge clk);
        verify_word("rd_data", exp, rd_data);
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Mid-cycle monitor, all DUT outputs settled
    always @(negedge clk) begin
        int in_stack;
        int pos;
        if (monitor_on) begin
            if (dut.u_wb.wb_props.fail_count != 0) begin
                $display("A bound assertion on write-back failed");
                stop_with_failure();
            end
            match_flag("inorder", mode_model, inorder);
            // The ID on the write port left the stack at the last edge
            in_stack = outstanding - (wb_valid ? 1 : 0);
            match_flag("id_available", in_stack < `WB_INFLIGHT, id_available);
            match_flag("queue_empty", in_stack == 0, queue_empty);
            if (wb_valid) begin
                if (!busy[wb_id]) begin
                    $display("Write-back for ID %0d, which has nothing in flight", wb_id);
                    stop_with_failure();
                end
                // Expected retirement order inside the group
                compare_id("wb_id", rank_id[group_pos], wb_id);
                check_reg_addr("wb_rd", exp_rd[wb_id], wb_rd);
                verify_word("wb_data", exp_data[wb_id], wb_data);
                busy[wb_id] = 1'b0;
                pos = -1;
                foreach (issue_order[i]) begin
                    if (issue_order[i] == wb_id)
                        pos = i;
                end
                if (pos >= 0)
                    issue_order.delete(pos);
                outstanding--;
                group_pos++;
            end
            // Oldest issued ID still held by the stack
            if (issue_order.size() != 0)
                compare_id("oldest_id", issue_order[0], oldest_id);
            // Mode for the coming edge, change held until the queue is empty
            if (cfg_write) begin
                mode_pending = 1'b1;
                mode_req     = cfg_inorder;
            end
            if (mode_pending && in_stack == 0) begin
                mode_model   = mode_req;
                mode_pending = 1'b0;
            end
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst         = 1'b1;
        issue       = 1'b0;
        issue_unit  = UNIT_ALU;
        issue_op    = OP_ADD;
        issue_rd    = '0;
        issue_a     = '0;
        issue_b     = '0;
        cfg_write   = 1'b0;
        cfg_inorder = 1'b1;
        rd_addr     = '0;
        monitor_on  = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        outstanding = 0;
        group_pos   = 0;
        mode_model   = 1'b1;
        mode_pending = 1'b0;
        mode_req     = 1'b1;
        foreach (busy[i])
            busy[i] = 1'b0;
        void'($urandom(32'h932f_0e2b));
        load_tests();
        cycle_limit = CYCLES_PER_RECORD * rec_count + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        monitor_on = 1'b1;

        for (int r = 0; r < rec_count; r++) begin
            case (rec_kind[r])
                "M": write_mode(rec_f[r][0][0]);
                "I": issue_instr(r);
                "D": drain_queue();
                "R": read_register(reg_addr_t'(rec_f[r][0][4:0]), rec_f[r][1]);
                default: begin
                    $display("Unknown record kind in wb_tests.txt, record %0d", r);
                    stop_with_failure();
                end
            endcase
        end
        drain_queue();
        tick();

        if (dut.u_wb.wb_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", dut.u_wb.wb_props.fail_count);
            stop_with_failure();
        end
    end

endmodule

/* wb_properties.sv */
/*
 * Concurrent checks bound into write_back
 * fail_count holds the number of failed assertions
 */
`include "wb_settings.svh"

module wb_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    inorder,
    input logic                    issue,
    input wb_pkg::instruction_id_t issue_id,
    input logic                    retire,
    input wb_pkg::instruction_id_t retire_id,
    input logic                    wb_valid,
    input wb_pkg::instruction_id_t wb_id
);
    import wb_pkg::*;

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    logic [`WB_INFLIGHT-1:0] busy_r;
    logic [`WB_INFLIGHT-1:0] busy_nxt;

    // Issue stamps give the age of each ID still in the stack
    logic [`WB_INFLIGHT-1:0] live_r;
    int unsigned             stamp_r [`WB_INFLIGHT];
    int unsigned             issue_seq;
    instruction_id_t         model_oldest;

    // IDs issued and not yet written back, a same-edge reissue wins
    always_comb begin
        busy_nxt = busy_r;
        if (wb_valid)
            busy_nxt[wb_id] = 1'b0;
        if (issue)
            busy_nxt[issue_id] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_r <= '0;
        end else begin
            busy_r <= busy_nxt;
        end
    end

    // IDs issued and not yet retired, stamped in issue order
    always_ff @(posedge clk) begin
        if (rst) begin
            live_r    <= '0;
            issue_seq <= 0;
        end else begin
            if (retire)
                live_r[retire_id] <= 1'b0;
            if (issue) begin
                live_r[issue_id]  <= 1'b1;
                stamp_r[issue_id] <= issue_seq;
                issue_seq         <= issue_seq + 1;
            end
        end
    end

    // Lowest stamp among the live IDs
    always_comb begin
        int unsigned best;
        best = '1;
        model_oldest = '0;
        for (int i = 0; i < `WB_INFLIGHT; i++) begin
            if (live_r[i] && stamp_r[i] < best) begin
                best = stamp_r[i];
                model_oldest = instruction_id_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back only for an ID in flight
    wb_id_in_flight: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> busy_r[wb_id])
        else begin
            fail_count++;
            $error("wb_valid for ID %0d that is not in flight", wb_id);
        end

    // In-order mode retires the oldest ID only
    inorder_oldest: assert property (@(posedge clk) disable iff (rst)
        (inorder && retire) |-> (retire_id == model_oldest))
        else begin
            fail_count++;
            $error("in-order retire of ID %0d, oldest is %0d", retire_id, model_oldest);
        end

endmodule

bind write_back wb_properties wb_props (
    .clk(clk), .rst(rst), .inorder(inorder), .issue(issue), .issue_id(issue_id),
    .retire(retire), .retire_id(retire_id),
    .wb_valid(wb_valid), .wb_id(wb_id)
);

/* wb_top.sv */
/*
 * Write-back subsystem top level
 * issue is a one-cycle strobe, allowed only while id_available is high
 * cfg_write takes effect once queue_empty is high
 */
`include "wb_settings.svh"

module wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  wb_pkg::unit_t           issue_unit,
    input  wb_pkg::alu_op_t         issue_op,
    input  wb_pkg::reg_addr_t       issue_rd,
    input  logic [`WB_XLEN-1:0]     issue_a,
    input  logic [`WB_XLEN-1:0]     issue_b,
    input  logic                    cfg_write,
    input  logic                    cfg_inorder,
    input  wb_pkg::reg_addr_t       rd_addr,
    output logic                    id_available,
    output wb_pkg::instruction_id_t issue_id,
    output logic                    queue_empty,
    output wb_pkg::instruction_id_t oldest_id,
    output logic                    inorder,
    output logic                    wb_valid,
    output wb_pkg::instruction_id_t wb_id,
    output wb_pkg::reg_addr_t       wb_rd,
    output logic [`WB_XLEN-1:0]     wb_data,
    output logic [`WB_XLEN-1:0]     rd_data
);
    import wb_pkg::*;

    instruction_id_t         ordering [`WB_INFLIGHT];
    instruction_id_t         retire_id;
    inflight_packet_t        issue_packet;
    logic                    retire;
    logic                    wb_nzero;
    logic [`WB_INFLIGHT-1:0] alu_done;
    logic [`WB_INFLIGHT-1:0] mul_done;
    logic [`WB_XLEN-1:0]     alu_result;
    logic [`WB_XLEN-1:0]     mul_result;

    // Bookkeeping for the packet table
    assign issue_packet.unit     = issue_unit;
    assign issue_packet.rd_addr  = issue_rd;
    assign issue_packet.rd_nzero = |issue_rd;

    wb_mode_ctrl u_mode (
        .clk(clk), .rst(rst), .cfg_write(cfg_write), .cfg_inorder(cfg_inorder),
        .queue_empty(queue_empty), .inorder(inorder)
    );

    id_order_stack u_stack (
        .clk(clk), .rst(rst), .issue(issue), .retire(retire), .retire_id(retire_id),
        .ordering(ordering), .next_id(issue_id), .id_available(id_available),
        .empty(queue_empty)
    );

    // Units read results by the ID being written back
    exec_units u_units (
        .clk(clk), .rst(rst), .issue(issue), .issue_unit(issue_unit),
        .issue_op(issue_op), .issue_id(issue_id), .issue_a(issue_a),
        .issue_b(issue_b), .retire_id(wb_id), .alu_done(alu_done),
        .mul_done(mul_done), .alu_result(alu_result), .mul_result(mul_result)
    );

    write_back u_wb (
        .clk(clk), .rst(rst), .inorder(inorder), .issue(issue), .issue_id(issue_id),
        .issue_packet(issue_packet), .ordering(ordering), .alu_done(alu_done),
        .mul_done(mul_done), .alu_result(alu_result), .mul_result(mul_result),
        .retire(retire), .retire_id(retire_id), .oldest_id(oldest_id),
        .wb_valid(wb_valid), .wb_id(wb_id), .wb_rd(wb_rd), .wb_nzero(wb_nzero),
        .wb_data(wb_data)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .wb_valid(wb_valid), .wb_nzero(wb_nzero),
        .wb_rd(wb_rd), .wb_data(wb_data), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

/* reg_file.sv */
/*
 * Register file with one write and one combinational read port
 * Register zero reads as zero and ignores writes
 */
`include "wb_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_valid,
    input  logic                wb_nzero,
    input  wb_pkg::reg_addr_t   wb_rd,
    input  logic [`WB_XLEN-1:0] wb_data,
    input  wb_pkg::reg_addr_t   rd_addr,
    output logic [`WB_XLEN-1:0] rd_data
);
    logic [`WB_XLEN-1:0] regs [`WB_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `WB_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_valid && wb_nzero) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Zero register forced on the read side as well
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

/* exec_units.sv */
/*
 * Single-cycle ALU and pipelined multiplier
 * Results are held per ID and read by the write-back ID
 * The multiplier keeps the low word of the product
 */
`include "wb_settings.svh"

module exec_units (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  wb_pkg::unit_t           issue_unit,
    input  wb_pkg::alu_op_t         issue_op,
    input  wb_pkg::instruction_id_t issue_id,
    input  logic [`WB_XLEN-1:0]     issue_a,
    input  logic [`WB_XLEN-1:0]     issue_b,
    input  wb_pkg::instruction_id_t retire_id,
    output logic [`WB_INFLIGHT-1:0] alu_done,
    output logic [`WB_INFLIGHT-1:0] mul_done,
    output logic [`WB_XLEN-1:0]     alu_result,
    output logic [`WB_XLEN-1:0]     mul_result
);
    import wb_pkg::*;

    localparam int LAST = `WB_MUL_STAGES - 1;

    logic [`WB_XLEN-1:0] alu_value;
    logic [`WB_XLEN-1:0] alu_res_r [`WB_INFLIGHT];
    logic [`WB_XLEN-1:0] mul_res_r [`WB_INFLIGHT];

    // Multiplier pipeline, the ID travels with each item
    logic                mul_valid [`WB_MUL_STAGES];
    instruction_id_t     mul_id [`WB_MUL_STAGES];
    logic [`WB_XLEN-1:0] mul_prod [`WB_MUL_STAGES];

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (issue_op)
            OP_ADD:  alu_value = issue_a + issue_b;
            OP_SUB:  alu_value = issue_a - issue_b;
            OP_AND:  alu_value = issue_a & issue_b;
            OP_OR:   alu_value = issue_a | issue_b;
            OP_XOR:  alu_value = issue_a ^ issue_b;
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_done <= '0;
        if (issue && issue_unit == UNIT_ALU) begin
            alu_done[issue_id]  <= 1'b1;
            alu_res_r[issue_id] <= alu_value;
        end
        if (rst)
            alu_done <= '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Multiplier
    always_ff @(posedge clk) begin
        mul_valid[0] <= issue && (issue_unit == UNIT_MUL);
        mul_id[0]    <= issue_id;
        mul_prod[0]  <= issue_a * issue_b;
        for (int s = 1; s < `WB_MUL_STAGES; s++) begin
            mul_valid[s] <= mul_valid[s - 1];
            mul_id[s]    <= mul_id[s - 1];
            mul_prod[s]  <= mul_prod[s - 1];
        end
        // Hold the result once it leaves the pipe
        if (mul_valid[LAST])
            mul_res_r[mul_id[LAST]] <= mul_prod[LAST];
        if (rst) begin
            for (int s = 0; s < `WB_MUL_STAGES; s++)
                mul_valid[s] <= 1'b0;
        end
    end

    always_comb begin
        mul_done = '0;
        mul_done[mul_id[LAST]] = mul_valid[LAST];
    end

    assign alu_result = alu_res_r[retire_id];
    assign mul_result = mul_res_r[retire_id];

endmodule

/* wb_mode_ctrl.sv */
/*
 * In-order mode register, set after reset
 * A written mode waits until the in-flight queue is empty
 */
module wb_mode_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cfg_write,
    input  logic cfg_inorder,
    input  logic queue_empty,
    output logic inorder
);
    logic pending;
    logic pending_valid;
    logic req_valid;
    logic req_value;

    // Fresh write wins over an older pending one
    assign req_valid = cfg_write | pending_valid;
    assign req_value = cfg_write ? cfg_inorder : pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            inorder       <= 1'b1;
            pending_valid <= 1'b0;
        end else if (req_valid && queue_empty) begin
            // Nothing in flight so nothing can be reordered
            inorder       <= req_value;
            pending_valid <= 1'b0;
        end else if (cfg_write) begin
            pending_valid <= 1'b1;
        end
        if (cfg_write)
            pending <= cfg_inorder;
    end

endmodule

/* write_back.sv */
/*
 * Retires at most one instruction per cycle
 * In-order mode waits on the oldest ID, out-of-order takes the oldest done
 * Unit results must stay valid for an ID until its wb_valid cycle ends
 */
`include "wb_settings.svh"

module write_back (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inorder,
    input  logic                     issue,
    input  wb_pkg::instruction_id_t  issue_id,
    input  wb_pkg::inflight_packet_t issue_packet,
    input  wb_pkg::instruction_id_t  ordering [`WB_INFLIGHT],
    input  logic [`WB_INFLIGHT-1:0]  alu_done,
    input  logic [`WB_INFLIGHT-1:0]  mul_done,
    input  logic [`WB_XLEN-1:0]      alu_result,
    input  logic [`WB_XLEN-1:0]      mul_result,
    output logic                     retire,
    output wb_pkg::instruction_id_t  retire_id,
    output wb_pkg::instruction_id_t  oldest_id,
    output logic                     wb_valid,
    output wb_pkg::instruction_id_t  wb_id,
    output wb_pkg::reg_addr_t        wb_rd,
    output logic                     wb_nzero,
    output logic [`WB_XLEN-1:0]      wb_data
);
    import wb_pkg::*;

    localparam int TOP = `WB_INFLIGHT - 1;

    // Unit, destination and nonzero flag of each in-flight ID
    inflight_packet_t packet_table [`WB_INFLIGHT];
    inflight_packet_t retired_packet;

    logic [`WB_INFLIGHT-1:0] id_done;
    logic [`WB_INFLIGHT-1:0] id_done_r;
    logic [`WB_INFLIGHT-1:0] id_done_ordered;
    logic [`WB_INFLIGHT-1:0] retired_last_cycle;
    logic                    retire_r;
    instruction_id_t         retire_id_r;
    instruction_id_t         sel_id;

    always_ff @(posedge clk) begin
        if (issue)
            packet_table[issue_id] <= issue_packet;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending-done tracking
    always_comb begin
        retired_last_cycle = '0;
        retired_last_cycle[retire_id_r] = retire_r;
    end

    // Done bits stay set until the cycle after their retirement
    assign id_done = (id_done_r & ~retired_last_cycle) | alu_done | mul_done;

    always_ff @(posedge clk) begin
        if (rst)
            id_done_r <= '0;
        else
            id_done_r <= id_done;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retire selection
    always_comb begin
        for (int i = 0; i < `WB_INFLIGHT; i++)
            id_done_ordered[i] = id_done[ordering[i]];
        sel_id = ordering[TOP];
        // Highest done position is the oldest done
        if (!inorder) begin
            for (int i = 0; i < `WB_INFLIGHT; i++) begin
                if (id_done_ordered[i])
                    sel_id = ordering[i];
            end
        end
    end

    assign retire    = inorder ? id_done_ordered[TOP] : |id_done;
    assign retire_id = sel_id;
    assign oldest_id = ordering[TOP];

    always_ff @(posedge clk) begin
        if (rst)
            retire_r <= 1'b0;
        else
            retire_r <= retire;
        retire_id_r <= retire_id;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file write port, one cycle after the decision
    assign retired_packet = packet_table[retire_id_r];
    assign wb_valid = retire_r;
    assign wb_id    = retire_id_r;
    assign wb_rd    = retired_packet.rd_addr;
    assign wb_nzero = retired_packet.rd_nzero;
    assign wb_data  = (retired_packet.unit == UNIT_MUL) ? mul_result : alu_result;

endmodule

/* id_order_stack.sv */
/*
 * Age-ordered stack of instruction IDs
 * issue must only be raised while id_available is high
 * retire_id must name an ID that is in flight
 */
`include "wb_settings.svh"

module id_order_stack (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  logic                    retire,
    input  wb_pkg::instruction_id_t retire_id,
    output wb_pkg::instruction_id_t ordering [`WB_INFLIGHT],
    output wb_pkg::instruction_id_t next_id,
    output logic                    id_available,
    output logic                    empty
);
    import wb_pkg::*;

    localparam int TOP   = `WB_INFLIGHT - 1;
    localparam int CNT_W = $clog2(`WB_INFLIGHT + 1);

    // Position 0 is the next free ID, position TOP the oldest in flight
    instruction_id_t order_r [`WB_INFLIGHT];
    instruction_id_t order_nxt [`WB_INFLIGHT];
    logic [CNT_W-1:0] count_r;
    logic [CNT_W-1:0] count_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Next ordering, issue applied first so a same-cycle retire
    // cannot hand its ID out again before it lands in the free region
    always_comb begin
        int free_top;
        logic found;
        order_nxt = order_r;
        count_nxt = count_r;
        free_top = TOP - int'(count_r);
        found = 1'b0;
        if (issue) begin
            // Free entries below the new ID slide down by one
            for (int i = 0; i < TOP; i++) begin
                if (i < free_top)
                    order_nxt[i] = order_nxt[i + 1];
            end
            // New ID sits just under the youngest in flight
            order_nxt[free_top] = order_r[0];
            count_nxt = count_nxt + 1'b1;
        end
        if (retire) begin
            // Entries below the retired ID move up, older ones stay put
            for (int i = TOP; i > 0; i--) begin
                if (order_nxt[i] == retire_id)
                    found = 1'b1;
                if (found)
                    order_nxt[i] = order_nxt[i - 1];
            end
            order_nxt[0] = retire_id;
            count_nxt = count_nxt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_r <= '0;
            for (int i = 0; i < `WB_INFLIGHT; i++)
                order_r[i] <= instruction_id_t'(i);
        end else begin
            count_r <= count_nxt;
            order_r <= order_nxt;
        end
    end

    assign ordering     = order_r;
    assign next_id      = order_r[0];
    assign id_available = (count_r != CNT_W'(`WB_INFLIGHT));
    assign empty        = (count_r == '0);

endmodule

/* wb_pkg.sv */
/*
 * Shared types of the write-back subsystem
 * Widths follow the macros of the settings header
 */
`include "wb_settings.svh"

package wb_pkg;

    // Tag carried by every issued instruction
    typedef logic [`WB_ID_W-1:0] instruction_id_t;

    // Destination register address
    typedef logic [$clog2(`WB_NUM_REGS)-1:0] reg_addr_t;

    // Execution unit select
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_t;

    // Operation codes, OP_MUL only meaningful on the multiplier
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } alu_op_t;

    // Per-ID bookkeeping held by write-back until retirement
    typedef struct packed {
        unit_t     unit;
        reg_addr_t rd_addr;
        logic      rd_nzero;
    } inflight_packet_t;

endpackage

/* wb_settings.svh */
/*
 * Global sizes of the write-back subsystem
 * WB_ID_W must equal clog2 of WB_INFLIGHT
 * WB_MUL_STAGES must be at least 1
 */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Data word width
`define WB_XLEN       32
// Instruction IDs in flight and their width
`define WB_INFLIGHT   4
`define WB_ID_W       2
// Architectural registers
`define WB_NUM_REGS   32
// Multiplier latency in stages
`define WB_MUL_STAGES 3

`endif
